// File: design/mem_pkg.sv
/* memory side shared types and constants */

`default_nettype none

package mem_pkg;

  // byte bus address rules
  localparam int ADDR_MSB = 17; // only bits 17:0 reach memory

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [7:0]  byte_t;
  typedef logic [1:0]  size_t;

  localparam size_t SIZE_BYTE = 2'd0;
  localparam size_t SIZE_HALF = 2'd1;
  localparam size_t SIZE_WORD = 2'd2;

  localparam logic [1:0] IO_SELECT = 2'b11; // addr[17:16] of the i/o range

  // direct-mapped icache, one word per line
  localparam int ICACHE_LINES   = 16;
  localparam int ICACHE_INDEX_W = 4;

  typedef logic [ICACHE_INDEX_W-1:0] icache_index_t;
  typedef logic [ADDR_MSB-ICACHE_INDEX_W-2:0] icache_tag_t; // addr[17:6]

  // owner of the sequencer
  typedef enum logic [1:0] {
    CLIENT_NONE,
    CLIENT_FETCH,
    CLIENT_LOAD,
    CLIENT_STORE
  } client_t;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_READ,
    SEQ_WRITE,
    SEQ_FINISH
  } seq_state_t;

endpackage

`default_nettype wire

// File: design/icache.sv
/* direct-mapped instruction cache */

`timescale 1ns/1ps
`default_nettype none

module icache (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   rdy_in,
  input  logic                   fetch_en,
  input  mem_pkg::addr_t         fetch_addr,
  input  logic                   flush_in,
  output logic                   fetch_done,
  output mem_pkg::word_t         fetch_data,
  output logic                   refill_req,
  output mem_pkg::addr_t         refill_addr,
  input  logic                   refill_done,
  input  mem_pkg::word_t         refill_data
);

  logic [mem_pkg::ICACHE_LINES-1:0] line_valid;
  mem_pkg::icache_tag_t             tag_mem [mem_pkg::ICACHE_LINES];
  mem_pkg::word_t                   data_mem [mem_pkg::ICACHE_LINES];

  mem_pkg::icache_index_t fetch_idx;
  mem_pkg::icache_tag_t   fetch_tag;
  mem_pkg::icache_index_t refill_idx;
  logic                   hit;
  logic                   miss_pending; // a refill is owed to the fetch client

  assign fetch_idx  = fetch_addr[mem_pkg::ICACHE_INDEX_W+1:2];
  assign fetch_tag  = fetch_addr[mem_pkg::ADDR_MSB:mem_pkg::ICACHE_INDEX_W+2];
  assign refill_idx = refill_addr[mem_pkg::ICACHE_INDEX_W+1:2];
  assign hit        = line_valid[fetch_idx] && (tag_mem[fetch_idx] == fetch_tag);

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      line_valid   <= '0;
      miss_pending <= 1'b0;
      fetch_done   <= 1'b0;
      refill_req   <= 1'b0;
    end
    else if (rdy_in)
    begin
      fetch_done <= 1'b0;
      refill_req <= 1'b0;
      if (refill_done)
      begin
        line_valid[refill_idx] <= 1'b1; // line fills even after a flush
        miss_pending           <= 1'b0;
        fetch_done             <= miss_pending && !flush_in;
      end
      if (fetch_en)
      begin
        if (hit)
          fetch_done <= 1'b1;
        else
        begin
          refill_req   <= 1'b1;
          miss_pending <= 1'b1;
        end
      end
      if (flush_in)
        miss_pending <= 1'b0; // branch flush drops the waiting fetch
    end
  end

  // line storage and returned words
  always_ff @(posedge clk_in)
  begin
    if (rdy_in)
    begin
      if (refill_done)
      begin
        tag_mem[refill_idx]  <= refill_addr[mem_pkg::ADDR_MSB:mem_pkg::ICACHE_INDEX_W+2];
        data_mem[refill_idx] <= refill_data;
        fetch_data           <= refill_data;
      end
      if (fetch_en && hit)
        fetch_data <= data_mem[fetch_idx];
      if (fetch_en && !hit)
        refill_addr <= fetch_addr;
    end
  end

  a_fetch_aligned: assert property (
    @(posedge clk_in) disable iff (rst_in)
    fetch_en |-> (fetch_addr[1:0] == 2'b00)
  );

endmodule

`default_nettype wire

// File: design/mem_arbiter.sv
/* memory request arbiter */

`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   rdy_in,
  input  logic                   refill_req,
  input  mem_pkg::addr_t         refill_addr,
  output logic                   refill_done,
  output mem_pkg::word_t         refill_data,
  input  logic                   load_en,
  input  mem_pkg::addr_t         load_addr,
  input  mem_pkg::size_t         load_size,
  output logic                   load_done,
  output mem_pkg::word_t         load_data,
  input  logic                   store_en,
  input  mem_pkg::addr_t         store_addr,
  input  mem_pkg::size_t         store_size,
  input  mem_pkg::word_t         store_data,
  output logic                   store_done,
  output logic                   seq_start,
  output mem_pkg::addr_t         seq_addr,
  output mem_pkg::size_t         seq_size,
  output logic                   seq_write,
  output mem_pkg::word_t         seq_wdata,
  input  logic                   seq_done,
  input  mem_pkg::word_t         seq_rdata
);

  logic refill_pend, load_pend, store_pend;

  mem_pkg::addr_t  refill_addr_q, load_addr_q, store_addr_q;
  mem_pkg::size_t  load_size_q, store_size_q;
  mem_pkg::word_t  store_data_q;
  mem_pkg::word_t  rdata_q;
  mem_pkg::client_t grant;
  mem_pkg::client_t pick;

  // data clients ahead of the refill
  always_comb
  begin
    pick = mem_pkg::CLIENT_NONE;
    if (grant == mem_pkg::CLIENT_NONE)
    begin
      if (store_pend)
        pick = mem_pkg::CLIENT_STORE;
      else if (load_pend)
        pick = mem_pkg::CLIENT_LOAD;
      else if (refill_pend)
        pick = mem_pkg::CLIENT_FETCH;
    end
  end

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      refill_pend <= 1'b0;
      load_pend   <= 1'b0;
      store_pend  <= 1'b0;
      grant       <= mem_pkg::CLIENT_NONE;
      seq_start   <= 1'b0;
      refill_done <= 1'b0;
      load_done   <= 1'b0;
      store_done  <= 1'b0;
    end
    else if (rdy_in)
    begin
      refill_done <= 1'b0;
      load_done   <= 1'b0;
      store_done  <= 1'b0;
      seq_start   <= (pick != mem_pkg::CLIENT_NONE);
      if (pick != mem_pkg::CLIENT_NONE)
        grant <= pick;
      case (pick)
        mem_pkg::CLIENT_STORE: store_pend  <= 1'b0;
        mem_pkg::CLIENT_LOAD:  load_pend   <= 1'b0;
        mem_pkg::CLIENT_FETCH: refill_pend <= 1'b0;
        default: ;
      endcase
      if (seq_done)
      begin
        grant       <= mem_pkg::CLIENT_NONE;
        refill_done <= (grant == mem_pkg::CLIENT_FETCH);
        load_done   <= (grant == mem_pkg::CLIENT_LOAD);
        store_done  <= (grant == mem_pkg::CLIENT_STORE);
      end
      if (refill_req)
        refill_pend <= 1'b1;
      if (load_en)
        load_pend <= 1'b1;
      if (store_en)
        store_pend <= 1'b1;
    end
  end

  // request payloads and the command to the sequencer
  always_ff @(posedge clk_in)
  begin
    if (rdy_in)
    begin
      if (refill_req)
        refill_addr_q <= refill_addr;
      if (load_en)
      begin
        load_addr_q <= load_addr;
        load_size_q <= load_size;
      end
      if (store_en)
      begin
        store_addr_q <= store_addr;
        store_size_q <= store_size;
        store_data_q <= store_data;
      end
      case (pick)
        mem_pkg::CLIENT_STORE:
        begin
          seq_addr  <= store_addr_q;
          seq_size  <= store_size_q;
          seq_write <= 1'b1;
          seq_wdata <= store_data_q;
        end
        mem_pkg::CLIENT_LOAD:
        begin
          seq_addr  <= load_addr_q;
          seq_size  <= load_size_q;
          seq_write <= 1'b0;
        end
        mem_pkg::CLIENT_FETCH:
        begin
          seq_addr  <= refill_addr_q;
          seq_size  <= mem_pkg::SIZE_WORD; // refills are whole words
          seq_write <= 1'b0;
        end
        default: ;
      endcase
      if (seq_done)
        rdata_q <= seq_rdata;
    end
  end

  assign refill_data = rdata_q;
  assign load_data   = rdata_q;

  // a done only closes the command in flight, never overlaps a new start
  a_one_grant: assert property (
    @(posedge clk_in) disable iff (rst_in)
    seq_done |-> ((grant != mem_pkg::CLIENT_NONE) && !seq_start)
  );

endmodule

`default_nettype wire

// File: design/byte_sequencer.sv
/* byte bus sequencer */

`timescale 1ns/1ps
`default_nettype none

module byte_sequencer (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   rdy_in,
  input  logic                   seq_start,
  input  mem_pkg::addr_t         seq_addr,
  input  mem_pkg::size_t         seq_size,
  input  logic                   seq_write,
  input  mem_pkg::word_t         seq_wdata,
  output logic                   seq_done,
  output mem_pkg::word_t         seq_rdata,
  input  logic                   io_buffer_full,
  input  mem_pkg::byte_t         mem_din,
  output mem_pkg::byte_t         mem_dout,
  output mem_pkg::addr_t         mem_a,
  output logic                   mem_wr
);

  mem_pkg::seq_state_t state;

  logic [1:0]      byte_cnt;   // byte now on the bus
  logic [1:0]      last_cnt;
  logic [1:0]      last_sel;
  logic [1:0]      cap_idx;    // lane of the byte arriving on mem_din
  logic            cap_en;
  logic            rdy_q;
  logic            io_stall;
  mem_pkg::word_t  wdata_q;    // bytes still to be written, low first
  mem_pkg::byte_t  din_hold;
  mem_pkg::byte_t  cap_byte;

  always_comb
  begin
    case (seq_size)
      mem_pkg::SIZE_BYTE: last_sel = 2'd0;
      mem_pkg::SIZE_HALF: last_sel = 2'd1;
      default:            last_sel = 2'd3;
    endcase
  end

  assign io_stall = (mem_a[mem_pkg::ADDR_MSB -: 2] == mem_pkg::IO_SELECT) && io_buffer_full;
  assign mem_wr   = (state == mem_pkg::SEQ_WRITE) && rdy_in && !io_stall;

  // memory answers even while paused, so the byte that arrived
  // in the first paused cycle is kept until the pause ends
  always_ff @(posedge clk_in)
  begin
    if (rst_in)
      rdy_q <= 1'b0;
    else
      rdy_q <= rdy_in;
    if (rdy_q)
      din_hold <= mem_din;
  end

  assign cap_byte = rdy_q ? mem_din : din_hold;

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      state    <= mem_pkg::SEQ_IDLE;
      byte_cnt <= 2'd0;
      cap_en   <= 1'b0;
      seq_done <= 1'b0;
      mem_a    <= '0;
    end
    else if (rdy_in)
    begin
      seq_done <= 1'b0;
      cap_en   <= 1'b0;
      case (state)
        mem_pkg::SEQ_IDLE:
          if (seq_start)
          begin
            mem_a    <= seq_addr;
            byte_cnt <= 2'd0;
            state    <= seq_write ? mem_pkg::SEQ_WRITE : mem_pkg::SEQ_READ;
          end
        mem_pkg::SEQ_READ:
        begin
          cap_en <= 1'b1; // data comes back next cycle
          if (byte_cnt == last_cnt)
            state <= mem_pkg::SEQ_FINISH;
          else
          begin
            byte_cnt <= byte_cnt + 2'd1;
            mem_a    <= mem_a + 32'd1;
          end
        end
        mem_pkg::SEQ_WRITE:
          if (!io_stall)
          begin
            if (byte_cnt == last_cnt)
            begin
              seq_done <= 1'b1;
              state    <= mem_pkg::SEQ_IDLE;
            end
            else
            begin
              byte_cnt <= byte_cnt + 2'd1;
              mem_a    <= mem_a + 32'd1;
            end
          end
        default:
        begin
          seq_done <= 1'b1; // last byte captured this cycle
          state    <= mem_pkg::SEQ_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_in)
  begin
    if (rdy_in)
    begin
      if (state == mem_pkg::SEQ_IDLE && seq_start)
      begin
        last_cnt  <= last_sel;
        mem_dout  <= seq_wdata[7:0];
        wdata_q   <= seq_wdata >> 8;
        seq_rdata <= '0; // zero-extend short loads
      end
      if (state == mem_pkg::SEQ_WRITE && !io_stall && byte_cnt != last_cnt)
      begin
        mem_dout <= wdata_q[7:0];
        wdata_q  <= wdata_q >> 8;
      end
      if (state == mem_pkg::SEQ_READ)
        cap_idx <= byte_cnt;
      if (cap_en)
        seq_rdata[{cap_idx, 3'b000} +: 8] <= cap_byte; // little-endian lane
    end
  end

  // each address gets one write strobe, across pauses and stalls too
  a_byte_written_once: assert property (
    @(posedge clk_in) disable iff (rst_in)
    mem_wr |=> (!mem_wr || (mem_a != $past(mem_a)))
  );

endmodule

`default_nettype wire

// File: design/mem_unit.sv
/* memory unit top */

`timescale 1ns/1ps
`default_nettype none

module mem_unit (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   rdy_in,
  input  logic                   fetch_en,
  input  mem_pkg::addr_t         fetch_addr,
  output logic                   fetch_done,
  output mem_pkg::word_t         fetch_data,
  input  logic                   load_en,
  input  mem_pkg::addr_t         load_addr,
  input  mem_pkg::size_t         load_size,
  output logic                   load_done,
  output mem_pkg::word_t         load_data,
  input  logic                   store_en,
  input  mem_pkg::addr_t         store_addr,
  input  mem_pkg::size_t         store_size,
  input  mem_pkg::word_t         store_data,
  output logic                   store_done,
  input  logic                   flush_in,
  input  logic                   io_buffer_full,
  input  mem_pkg::byte_t         mem_din,
  output mem_pkg::byte_t         mem_dout,
  output mem_pkg::addr_t         mem_a,
  output logic                   mem_wr
);

  logic            refill_req;
  mem_pkg::addr_t  refill_addr;
  logic            refill_done;
  mem_pkg::word_t  refill_data;

  logic            seq_start;
  mem_pkg::addr_t  seq_addr;
  mem_pkg::size_t  seq_size;
  logic            seq_write;
  mem_pkg::word_t  seq_wdata;
  logic            seq_done;
  mem_pkg::word_t  seq_rdata;

  icache icache0 (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .fetch_en       (fetch_en),
    .fetch_addr     (fetch_addr),
    .flush_in       (flush_in),
    .fetch_done     (fetch_done),
    .fetch_data     (fetch_data),
    .refill_req     (refill_req),
    .refill_addr    (refill_addr),
    .refill_done    (refill_done),
    .refill_data    (refill_data)
  );

  mem_arbiter arbiter0 (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .refill_req     (refill_req),
    .refill_addr    (refill_addr),
    .refill_done    (refill_done),
    .refill_data    (refill_data),
    .load_en        (load_en),
    .load_addr      (load_addr),
    .load_size      (load_size),
    .load_done      (load_done),
    .load_data      (load_data),
    .store_en       (store_en),
    .store_addr     (store_addr),
    .store_size     (store_size),
    .store_data     (store_data),
    .store_done     (store_done),
    .seq_start      (seq_start),
    .seq_addr       (seq_addr),
    .seq_size       (seq_size),
    .seq_write      (seq_write),
    .seq_wdata      (seq_wdata),
    .seq_done       (seq_done),
    .seq_rdata      (seq_rdata)
  );

  byte_sequencer seq0 (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .seq_start      (seq_start),
    .seq_addr       (seq_addr),
    .seq_size       (seq_size),
    .seq_write      (seq_write),
    .seq_wdata      (seq_wdata),
    .seq_done       (seq_done),
    .seq_rdata      (seq_rdata),
    .io_buffer_full (io_buffer_full),
    .mem_din        (mem_din),
    .mem_dout       (mem_dout),
    .mem_a          (mem_a),
    .mem_wr         (mem_wr)
  );

endmodule

`default_nettype wire

// File: tb/tb_mem_unit.sv
/* memory unit testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_mem_unit;

  localparam int NUM_OPS      = 400;
  localparam int PAUSE_LIMIT  = 64;  // edges spent waiting for rdy_in
  localparam int DONE_LIMIT   = 200; // active cycles spent waiting for a done
  localparam int FLUSH_WINDOW = 40;

  logic           clk_in = 1'b0;
  logic           rst_in;
  logic           rdy_in;
  logic           fetch_en;
  mem_pkg::addr_t fetch_addr;
  logic           fetch_done;
  mem_pkg::word_t fetch_data;
  logic           load_en;
  mem_pkg::addr_t load_addr;
  mem_pkg::size_t load_size;
  logic           load_done;
  mem_pkg::word_t load_data;
  logic           store_en;
  mem_pkg::addr_t store_addr;
  mem_pkg::size_t store_size;
  mem_pkg::word_t store_data;
  logic           store_done;
  logic           flush_in;
  logic           io_buffer_full;
  mem_pkg::byte_t mem_din = '0;
  mem_pkg::byte_t mem_dout;
  mem_pkg::addr_t mem_a;
  logic           mem_wr;

  mem_pkg::byte_t       mem [0:131071];     // bus side memory
  mem_pkg::byte_t       ref_mem [0:131071]; // expected contents
  mem_pkg::byte_t       io_q [$];           // bytes written to the i/o range
  logic [15:0]          line_valid;
  mem_pkg::icache_tag_t line_tag [16];
  int                   err_cnt = 0;

  mem_unit dut0 (
    .clk_in(clk_in), .rst_in(rst_in), .rdy_in(rdy_in),
    .fetch_en(fetch_en), .fetch_addr(fetch_addr),
    .fetch_done(fetch_done), .fetch_data(fetch_data),
    .load_en(load_en), .load_addr(load_addr), .load_size(load_size),
    .load_done(load_done), .load_data(load_data),
    .store_en(store_en), .store_addr(store_addr), .store_size(store_size),
    .store_data(store_data), .store_done(store_done),
    .flush_in(flush_in), .io_buffer_full(io_buffer_full),
    .mem_din(mem_din), .mem_dout(mem_dout), .mem_a(mem_a), .mem_wr(mem_wr)
  );

  always #10 clk_in = ~clk_in;

  always @(posedge clk_in)
  begin
    if (mem_wr)
    begin
      mem[mem_a[16:0]] <= mem_dout;
      if (mem_a[17:16] == mem_pkg::IO_SELECT)
        io_q.push_back(mem_dout);
    end
    mem_din <= mem[mem_a[16:0]]; // read data one cycle after the address
    if (!rst_in)
    begin
      check(32'(mem_wr && !rdy_in), 32'd0, "mem_wr high while paused");
      check(32'(mem_wr && io_buffer_full && mem_a[17:16] == mem_pkg::IO_SELECT), 32'd0,
            "i/o write while buffer full");
    end
  end

  function automatic mem_pkg::byte_t fill_byte(input int a);
    return mem_pkg::byte_t'(a ^ (a >> 7) ^ (a >> 13));
  endfunction

  function automatic int size_bytes(input mem_pkg::size_t sz);
    case (sz)
      mem_pkg::SIZE_BYTE: return 1;
      mem_pkg::SIZE_HALF: return 2;
      default:            return 4;
    endcase
  endfunction

  // little-endian, upper bytes stay zero
  function automatic mem_pkg::word_t ref_word(input mem_pkg::addr_t a, input int n);
    mem_pkg::word_t w;
    mem_pkg::addr_t ba;
    int             i;
    w = '0;
    for (i = 0; i < n; i++)
    begin
      ba = a + i;
      w[8*i +: 8] = ref_mem[ba[16:0]];
    end
    return w;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      err_cnt++;
      $display("** Error at %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s never completed", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // advance to the next edge the DUT sees with rdy_in high
  task automatic next_active(input string what);
    int   k;
    logic act;
    act = 1'b0;
    for (k = 0; k < PAUSE_LIMIT && !act; k++)
    begin
      @(posedge clk_in);
      act = rdy_in;
      rdy_in         <= ($urandom % 4) != 0;
      io_buffer_full <= ($urandom % 3) == 0;
    end
    if (!act)
      report_timeout(what);
  endtask

  task automatic wait_done(input int sel, input string what);
    int   k;
    logic seen;
    seen = 1'b0;
    for (k = 0; k < DONE_LIMIT && !seen; k++)
    begin
      next_active(what);
      case (sel)
        0:       seen = fetch_done;
        1:       seen = load_done;
        default: seen = store_done;
      endcase
    end
    if (!seen)
      report_timeout(what);
  endtask

  task automatic fetch_word(input mem_pkg::addr_t a);
    logic [3:0] idx;
    logic       hit;
    idx = a[5:2];
    hit = line_valid[idx] && line_tag[idx] == a[17:6];
    fetch_en   <= 1'b1;
    fetch_addr <= a;
    next_active("fetch request");
    fetch_en <= 1'b0;
    if (hit)
    begin
      next_active("fetch hit");
      check(32'(fetch_done), 32'd1, "fetch hit not done after 1 cycle");
    end
    else
      wait_done(0, "fetch miss");
    check(fetch_data, ref_word(a, 4), "fetch data");
    line_valid[idx] = 1'b1;
    line_tag[idx]   = a[17:6];
  endtask

  task automatic flush_miss(input mem_pkg::addr_t a);
    mem_pkg::addr_t m;
    int             k;
    m = a;
    if (line_valid[m[5:2]] && line_tag[m[5:2]] == m[17:6])
      m[6] = ~m[6]; // different tag on the same line
    fetch_en   <= 1'b1;
    fetch_addr <= m;
    next_active("flushed fetch request");
    fetch_en <= 1'b0;
    next_active("flush delay");
    flush_in <= 1'b1;
    next_active("flush");
    flush_in <= 1'b0;
    for (k = 0; k < FLUSH_WINDOW; k++)
    begin
      next_active("flush window");
      check(32'(fetch_done), 32'd0, "fetch_done after flush");
    end
    line_valid[m[5:2]] = 1'b1; // the refill still lands
    line_tag[m[5:2]]   = m[17:6];
    fetch_word(m);
  endtask

  task automatic load_bytes(input mem_pkg::addr_t a, input mem_pkg::size_t sz);
    load_en   <= 1'b1;
    load_addr <= a;
    load_size <= sz;
    next_active("load request");
    load_en <= 1'b0;
    wait_done(1, "load");
    check(load_data, ref_word(a, size_bytes(sz)), "load data");
  endtask

  task automatic store_bytes(input mem_pkg::addr_t a, input mem_pkg::size_t sz,
                             input mem_pkg::word_t d);
    mem_pkg::addr_t ba;
    int             n;
    int             k;
    logic           io;
    n  = size_bytes(sz);
    io = (a[17:16] == mem_pkg::IO_SELECT);
    store_en   <= 1'b1;
    store_addr <= a;
    store_size <= sz;
    store_data <= d;
    next_active("store request");
    store_en <= 1'b0;
    wait_done(2, "store");
    if (io)
      check(32'(io_q.size()), 32'(n), "i/o byte count");
    for (k = 0; k < n; k++)
    begin
      ba = a + k;
      if (io)
        check(32'(io_q.pop_front()), 32'(d[8*k +: 8]), "i/o byte order");
      else
        ref_mem[ba[16:0]] = d[8*k +: 8];
    end
  endtask

  initial
  begin
    mem_pkg::addr_t a;
    mem_pkg::addr_t last_store;
    int             op;
    int             i;
    void'($urandom(32'h3be0fb50));
    for (i = 0; i < 131072; i++)
    begin
      mem[17'(i)]     = fill_byte(i);
      ref_mem[17'(i)] = fill_byte(i);
    end
    line_valid     = '0;
    rst_in         <= 1'b1;
    rdy_in         <= 1'b1;
    io_buffer_full <= 1'b0;
    fetch_en       <= 1'b0;
    fetch_addr     <= '0;
    load_en        <= 1'b0;
    load_addr      <= '0;
    load_size      <= mem_pkg::SIZE_WORD;
    store_en       <= 1'b0;
    store_addr     <= '0;
    store_size     <= mem_pkg::SIZE_WORD;
    store_data     <= '0;
    flush_in       <= 1'b0;
    last_store     = 32'h1000;
    repeat (3) @(posedge clk_in);
    check(32'(mem_wr), 32'd0, "mem_wr after reset");
    check(32'(fetch_done), 32'd0, "fetch_done after reset");
    check(32'(load_done), 32'd0, "load_done after reset");
    check(32'(store_done), 32'd0, "store_done after reset");
    rst_in <= 1'b0;
    for (i = 0; i < NUM_OPS; i++)
    begin
      op = $urandom % 10;
      if (op < 4 || op == 9)
        a = ($urandom % 2 == 0) ? ($urandom % 24) << 2 : ($urandom % 1024) << 2;
      else
        a = 32'h1000 + $urandom % 32'h0ffd;
      case (op)
        0, 1, 2, 3: fetch_word(a);
        4, 5:       load_bytes(($urandom % 2 == 0) ? last_store : a,
                               mem_pkg::size_t'($urandom % 3));
        6, 7:
        begin
          store_bytes(a, mem_pkg::size_t'($urandom % 3), $urandom);
          last_store = a;
        end
        8:          store_bytes(32'h30000, mem_pkg::size_t'($urandom % 3), $urandom);
        default:    flush_miss(a);
      endcase
    end
    if (err_cnt == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: mem_unit.f
design/mem_pkg.sv
design/icache.sv
design/mem_arbiter.sv
design/byte_sequencer.sv
design/mem_unit.sv
tb/tb_mem_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the memory unit testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_mem_unit -f mem_unit.f -o sim_mem_unit \
  || { echo "build failed"; exit 1; }

result=$(./obj_dir/sim_mem_unit 2>&1)
echo "$result"

echo "$result" | grep -qx "Simulation passed" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
